/* src/armPkg.sv */
/* Shared widths, instruction field positions and encodings
   for the data-processing pipeline */
package armPkg;
   typedef logic [31:0] word_t;      // Data and instruction word
   typedef logic [3:0]  regIdx_t;
   typedef logic [3:0]  flags_t;     // N Z C V from the top bit
   typedef logic [3:0]  cond_t;
   typedef logic [1:0]  aluOp_t;
   typedef logic [1:0]  shiftType_t;
   typedef logic [4:0]  shiftAmt_t;

   localparam int NUM_REGS = 16;

   // Instruction field positions
   localparam int COND_LSB   = 28;
   localparam int OP_LSB     = 26;
   localparam int IMM_BIT    = 25;
   localparam int FUNCT_LSB  = 21;
   localparam int S_BIT      = 20;
   localparam int RN_LSB     = 16;
   localparam int RD_LSB     = 12;
   localparam int SHAMT_LSB  = 7;
   localparam int SHTYPE_LSB = 5;
   localparam int RM_LSB     = 0;

   localparam logic [1:0] OP_DATA = 2'b00;

   localparam logic [3:0] FUNCT_ADD = 4'b0100;
   localparam logic [3:0] FUNCT_SUB = 4'b0010;
   localparam logic [3:0] FUNCT_AND = 4'b0000;
   localparam logic [3:0] FUNCT_ORR = 4'b1100;

   localparam aluOp_t ALU_ADD = 2'b00;
   localparam aluOp_t ALU_SUB = 2'b01;
   localparam aluOp_t ALU_AND = 2'b10;
   localparam aluOp_t ALU_ORR = 2'b11;

   localparam shiftType_t SH_LSL = 2'b00;
   localparam shiftType_t SH_LSR = 2'b01;
   localparam shiftType_t SH_ASR = 2'b10;
   localparam shiftType_t SH_ROR = 2'b11;

   // Condition field where 1111 acts as never
   localparam cond_t COND_EQ = 4'b0000;
   localparam cond_t COND_NE = 4'b0001;
   localparam cond_t COND_CS = 4'b0010;
   localparam cond_t COND_CC = 4'b0011;
   localparam cond_t COND_MI = 4'b0100;
   localparam cond_t COND_PL = 4'b0101;
   localparam cond_t COND_VS = 4'b0110;
   localparam cond_t COND_VC = 4'b0111;
   localparam cond_t COND_HI = 4'b1000;
   localparam cond_t COND_LS = 4'b1001;
   localparam cond_t COND_GE = 4'b1010;
   localparam cond_t COND_LT = 4'b1011;
   localparam cond_t COND_GT = 4'b1100;
   localparam cond_t COND_LE = 4'b1101;
   localparam cond_t COND_AL = 4'b1110;
endpackage

/* src/instrDecoder.sv */
/* Instruction decoder that slices the fields of a strobed word
   and registers them as the decode stage */
module instrDecoder (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 instrValid,
   input  armPkg::word_t        instr,
   output logic                 dValid,
   output armPkg::regIdx_t      dRn,
   output armPkg::regIdx_t      dRm,
   output armPkg::regIdx_t      dRd,
   output armPkg::cond_t        dCond,
   output armPkg::aluOp_t       dAluOp,
   output logic                 dUseImm,
   output armPkg::word_t        dImm,
   output logic                 dSetFlags,
   output armPkg::shiftType_t   dShiftType,
   output armPkg::shiftAmt_t    dShiftAmt
);
   logic [3:0]     funct;
   logic           supported;
   logic           isData;
   armPkg::aluOp_t aluOp;

   assign funct  = instr[armPkg::FUNCT_LSB +: 4];
   assign isData = (instr[armPkg::OP_LSB +: 2] == armPkg::OP_DATA);

   // Opcode field to ALU operation
   always_comb
   begin
      supported = 1'b1;
      case (funct)
         armPkg::FUNCT_ADD: aluOp = armPkg::ALU_ADD;
         armPkg::FUNCT_SUB: aluOp = armPkg::ALU_SUB;
         armPkg::FUNCT_AND: aluOp = armPkg::ALU_AND;
         armPkg::FUNCT_ORR: aluOp = armPkg::ALU_ORR;
         default:
         begin
            aluOp     = armPkg::ALU_ADD;
            supported = 1'b0;    // Word is dropped here
         end
      endcase
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         dValid <= 1'b0;
      else
         dValid <= instrValid && isData && supported;
   end

   always_ff @(posedge clk)
   begin
      dRn        <= instr[armPkg::RN_LSB +: 4];
      dRm        <= instr[armPkg::RM_LSB +: 4];
      dRd        <= instr[armPkg::RD_LSB +: 4];
      dCond      <= instr[armPkg::COND_LSB +: 4];
      dAluOp     <= aluOp;
      dUseImm    <= instr[armPkg::IMM_BIT];
      dImm       <= {24'd0, instr[7:0]};    // Zero-extended imm8
      dSetFlags  <= instr[armPkg::S_BIT];
      dShiftType <= instr[armPkg::SHTYPE_LSB +: 2];
      dShiftAmt  <= instr[armPkg::SHAMT_LSB +: 5];
   end
endmodule

/* src/operandStage.sv */
/* Operand stage with the 16-entry register file, write-through
   reads and the execute stage register */
module operandStage (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 dValid,
   input  armPkg::regIdx_t      dRn,
   input  armPkg::regIdx_t      dRm,
   input  armPkg::regIdx_t      dRd,
   input  armPkg::cond_t        dCond,
   input  armPkg::aluOp_t       dAluOp,
   input  logic                 dUseImm,
   input  armPkg::word_t        dImm,
   input  logic                 dSetFlags,
   input  armPkg::shiftType_t   dShiftType,
   input  armPkg::shiftAmt_t    dShiftAmt,
   input  logic                 wbValid,
   input  armPkg::regIdx_t      wbReg,
   input  armPkg::word_t        wbData,
   output logic                 eValid,
   output armPkg::regIdx_t      eRn,
   output armPkg::regIdx_t      eRm,
   output armPkg::regIdx_t      eRd,
   output armPkg::cond_t        eCond,
   output armPkg::aluOp_t       eAluOp,
   output logic                 eUseImm,
   output armPkg::word_t        eImm,
   output logic                 eSetFlags,
   output armPkg::shiftType_t   eShiftType,
   output armPkg::shiftAmt_t    eShiftAmt,
   output armPkg::word_t        eOpA,
   output armPkg::word_t        eOpB
);
   armPkg::word_t regFile [armPkg::NUM_REGS];
   armPkg::word_t readA;
   armPkg::word_t readB;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < armPkg::NUM_REGS; i++)
            regFile[i] <= '0;
      end
      else if (wbValid)
         regFile[wbReg] <= wbData;
   end

   // A write landing on the same edge wins over the stored value
   assign readA = (wbValid && wbReg == dRn) ? wbData : regFile[dRn];
   assign readB = (wbValid && wbReg == dRm) ? wbData : regFile[dRm];

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         eValid <= 1'b0;
      else
         eValid <= dValid;
   end

   always_ff @(posedge clk)
   begin
      eRn        <= dRn;
      eRm        <= dRm;
      eRd        <= dRd;
      eCond      <= dCond;
      eAluOp     <= dAluOp;
      eUseImm    <= dUseImm;
      eImm       <= dImm;
      eSetFlags  <= dSetFlags;
      eShiftType <= dShiftType;
      eShiftAmt  <= dShiftAmt;
      eOpA       <= readA;
      eOpB       <= readB;
   end
endmodule

/* src/shiftAlu.sv */
/* Barrel shifter on the second operand followed by the
   ADD/SUB/AND/ORR unit with NZCV */
module shiftAlu (
   input  armPkg::word_t        opA,
   input  armPkg::word_t        opB,
   input  logic                 useImm,
   input  armPkg::word_t        imm,
   input  armPkg::shiftType_t   shiftType,
   input  armPkg::shiftAmt_t    shiftAmt,
   input  armPkg::aluOp_t       aluOp,
   output armPkg::word_t        result,
   output armPkg::flags_t       aluFlags
);
   armPkg::word_t shifted;
   armPkg::word_t srcB;
   armPkg::word_t addend;
   logic [32:0]   sum;
   logic          isSub;
   logic          isArith;
   logic          carry;
   logic          overflow;

   always_comb
   begin
      case (shiftType)
         armPkg::SH_LSL: shifted = opB << shiftAmt;
         armPkg::SH_LSR: shifted = opB >> shiftAmt;
         armPkg::SH_ASR: shifted = $signed(opB) >>> shiftAmt;
         default:
         begin
            if (shiftAmt == '0)
               shifted = opB;    // ROR #0 passes through
            else
               shifted = (opB >> shiftAmt) | (opB << (6'd32 - {1'b0, shiftAmt}));
         end
      endcase
   end

   assign srcB    = useImm ? imm : shifted;
   assign isSub   = (aluOp == armPkg::ALU_SUB);
   assign isArith = (aluOp == armPkg::ALU_ADD) || isSub;
   assign addend  = isSub ? ~srcB : srcB;    // a + ~b + 1 for SUB
   assign sum     = {1'b0, opA} + {1'b0, addend} + {32'd0, isSub};

   always_comb
   begin
      case (aluOp)
         armPkg::ALU_AND: result = opA & srcB;
         armPkg::ALU_ORR: result = opA | srcB;
         default:         result = sum[31:0];
      endcase
   end

   // Signed overflow when both inputs agree in sign and the sum does not
   assign carry    = isArith && sum[32];
   assign overflow = isArith && (opA[31] == addend[31]) && (sum[31] != opA[31]);
   assign aluFlags = {result[31], result == '0, carry, overflow};
endmodule

/* src/executeUnit.sv */
/* Execute stage with operand forwarding, condition check,
   the NZCV register and the writeback register */
module executeUnit (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 eValid,
   input  armPkg::regIdx_t      eRn,
   input  armPkg::regIdx_t      eRm,
   input  armPkg::regIdx_t      eRd,
   input  armPkg::cond_t        eCond,
   input  armPkg::aluOp_t       eAluOp,
   input  logic                 eUseImm,
   input  armPkg::word_t        eImm,
   input  logic                 eSetFlags,
   input  armPkg::shiftType_t   eShiftType,
   input  armPkg::shiftAmt_t    eShiftAmt,
   input  armPkg::word_t        eOpA,
   input  armPkg::word_t        eOpB,
   output logic                 wbValid,
   output armPkg::regIdx_t      wbReg,
   output armPkg::word_t        wbData,
   output armPkg::flags_t       flags
);
   armPkg::word_t  opA;
   armPkg::word_t  opB;
   armPkg::word_t  result;
   armPkg::flags_t aluFlags;
   logic           n, z, c, v;
   logic           condPass;
   logic           execute;

   // Previous instruction still sits in the writeback register
   assign opA = (wbValid && wbReg == eRn) ? wbData : eOpA;
   assign opB = (wbValid && wbReg == eRm) ? wbData : eOpB;

   shiftAlu u_shiftAlu (
      .opA       (opA),
      .opB       (opB),
      .useImm    (eUseImm),
      .imm       (eImm),
      .shiftType (eShiftType),
      .shiftAmt  (eShiftAmt),
      .aluOp     (eAluOp),
      .result    (result),
      .aluFlags  (aluFlags)
   );

   assign {n, z, c, v} = flags;

   always_comb
   begin
      case (eCond)
         armPkg::COND_EQ: condPass = z;
         armPkg::COND_NE: condPass = !z;
         armPkg::COND_CS: condPass = c;
         armPkg::COND_CC: condPass = !c;
         armPkg::COND_MI: condPass = n;
         armPkg::COND_PL: condPass = !n;
         armPkg::COND_VS: condPass = v;
         armPkg::COND_VC: condPass = !v;
         armPkg::COND_HI: condPass = c && !z;
         armPkg::COND_LS: condPass = !c || z;
         armPkg::COND_GE: condPass = (n == v);
         armPkg::COND_LT: condPass = (n != v);
         armPkg::COND_GT: condPass = !z && (n == v);
         armPkg::COND_LE: condPass = z || (n != v);
         armPkg::COND_AL: condPass = 1'b1;
         default:         condPass = 1'b0;    // Never
      endcase
   end

   assign execute = eValid && condPass;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         wbValid <= 1'b0;
         flags   <= '0;
      end
      else
      begin
         wbValid <= execute;
         if (execute && eSetFlags)
         begin
            flags[3:2] <= aluFlags[3:2];
            // Logic ops keep C and V
            if (eAluOp == armPkg::ALU_ADD || eAluOp == armPkg::ALU_SUB)
               flags[1:0] <= aluFlags[1:0];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      wbReg  <= eRd;
      wbData <= result;
   end
endmodule

/* src/armCore.sv */
/* Three-stage data-processing core that decodes, reads operands,
   then executes and writes back */
module armCore (
   input  logic              clk,
   input  logic              reset,
   input  logic              instrValid,
   input  armPkg::word_t     instr,
   output logic              wbValid,
   output armPkg::regIdx_t   wbReg,
   output armPkg::word_t     wbData,
   output armPkg::flags_t    flags
);
   logic                dValid, dUseImm, dSetFlags;
   armPkg::regIdx_t     dRn, dRm, dRd;
   armPkg::cond_t       dCond;
   armPkg::aluOp_t      dAluOp;
   armPkg::word_t       dImm;
   armPkg::shiftType_t  dShiftType;
   armPkg::shiftAmt_t   dShiftAmt;

   logic                eValid, eUseImm, eSetFlags;
   armPkg::regIdx_t     eRn, eRm, eRd;
   armPkg::cond_t       eCond;
   armPkg::aluOp_t      eAluOp;
   armPkg::word_t       eImm, eOpA, eOpB;
   armPkg::shiftType_t  eShiftType;
   armPkg::shiftAmt_t   eShiftAmt;

   instrDecoder u_decoder (
      .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
      .dValid(dValid), .dRn(dRn), .dRm(dRm), .dRd(dRd), .dCond(dCond),
      .dAluOp(dAluOp), .dUseImm(dUseImm), .dImm(dImm), .dSetFlags(dSetFlags),
      .dShiftType(dShiftType), .dShiftAmt(dShiftAmt)
   );

   // Register file write port comes back from the writeback register
   operandStage u_operand (
      .clk(clk), .reset(reset), .dValid(dValid), .dRn(dRn), .dRm(dRm), .dRd(dRd),
      .dCond(dCond), .dAluOp(dAluOp), .dUseImm(dUseImm), .dImm(dImm),
      .dSetFlags(dSetFlags), .dShiftType(dShiftType), .dShiftAmt(dShiftAmt),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .eValid(eValid), .eRn(eRn), .eRm(eRm), .eRd(eRd), .eCond(eCond),
      .eAluOp(eAluOp), .eUseImm(eUseImm), .eImm(eImm), .eSetFlags(eSetFlags),
      .eShiftType(eShiftType), .eShiftAmt(eShiftAmt), .eOpA(eOpA), .eOpB(eOpB)
   );

   executeUnit u_execute (
      .clk(clk), .reset(reset), .eValid(eValid), .eRn(eRn), .eRm(eRm), .eRd(eRd),
      .eCond(eCond), .eAluOp(eAluOp), .eUseImm(eUseImm), .eImm(eImm),
      .eSetFlags(eSetFlags), .eShiftType(eShiftType), .eShiftAmt(eShiftAmt),
      .eOpA(eOpA), .eOpB(eOpB),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .flags(flags)
   );
endmodule

/* bench/armCoreTb.sv */
/* Testbench for armCore that replays the instruction trace and
   checks every writeback strobe against it */
module armCoreTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DRAIN_LIMIT = 50;    // Cycles allowed for the pipeline to empty
   localparam int LINE_LIMIT  = 1000;

   logic              clk;
   logic              reset;
   logic              instrValid;
   armPkg::word_t     instr;
   logic              wbValid;
   armPkg::regIdx_t   wbReg;
   armPkg::word_t     wbData;
   armPkg::flags_t    flags;

   int                errors = 0;
   int                edgeCount = 0;
   int                strobeCount = 0;
   int                expectedCount = 0;
   logic [31:0]       heldFlags = '0;    // Flags of the last executed instruction

   // Pending writebacks in issue order
   logic [31:0]       expEdge [$];
   logic [31:0]       expReg [$];
   logic [31:0]       expData [$];
   logic [31:0]       expFlags [$];

   armCore u_dut (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .wbValid    (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .flags      (flags)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
      edgeCount <= edgeCount + 1;    // Equals the edge number once the edge settles

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected)
      begin
         errors++;
         $display("FAILED at time %0t: %s expected %h, got %h",
                  $time, name, expected, actual);
      end
   endtask

   // Idle for gap cycles, then present the word for one sampling edge
   task automatic issueWord(input armPkg::word_t word, input int gap);
      repeat (gap)
      begin
         @(posedge clk);
         instrValid <= 1'b0;
      end
      @(posedge clk);
      instrValid <= 1'b1;
      instr      <= word;
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk)
   begin
      if (!reset && wbValid)
      begin
         strobeCount++;
         if (expData.size() == 0)
         begin
            errors++;
            $display("Unexpected writeback to R%0d with data %h at time %0t",
                     wbReg, wbData, $time);
         end
         else
         begin
            checkValue("wbValid cycle", edgeCount, expEdge.pop_front());
            checkValue("wbReg", 32'(wbReg), expReg.pop_front());
            checkValue("wbData", wbData, expData.pop_front());
            heldFlags = expFlags.pop_front();
            checkValue("flags", 32'(flags), heldFlags);
         end
      end
      else if (!reset)
         checkValue("flags", 32'(flags), heldFlags);    // Nothing executed, flags hold
   end

   initial
   begin
      int            fd;
      int            gap;
      int            wbFlag;
      int            nRead;
      int            lineCount;
      int            waitCycles;
      string         line;
      armPkg::word_t word;
      logic [31:0]   tReg;
      logic [31:0]   tData;
      logic [31:0]   tFlags;

      clk        = 1'b0;
      reset      = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkValue("wbValid", 32'(wbValid), 0);
      checkValue("flags", 32'(flags), 0);

      fd = $fopen("bench/trace.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("Could not open the trace file bench/trace.txt");
      end
      else
      begin
         lineCount = 0;
         while (!$feof(fd) && lineCount < LINE_LIMIT)
         begin
            lineCount++;
            nRead = $fgets(line, fd);
            if (nRead > 0 && line.len() > 1 && line.getc(0) != "#")
            begin
               if ($sscanf(line, "%h %d %d %h %h %h",
                           word, gap, wbFlag, tReg, tData, tFlags) != 6)
               begin
                  errors++;
                  $display("Malformed trace line: %s", line);
               end
               else
               begin
                  issueWord(word, gap);
                  if (wbFlag != 0)
                  begin
                     // Sampled at the next edge, visible two edges later
                     expEdge.push_back(edgeCount + 4);
                     expReg.push_back(tReg);
                     expData.push_back(tData);
                     expFlags.push_back(tFlags);
                     expectedCount++;
                  end
               end
            end
         end
         $fclose(fd);
      end
      @(posedge clk);
      instrValid <= 1'b0;

      waitCycles = 0;
      while (expData.size() != 0 && waitCycles < DRAIN_LIMIT)
      begin
         @(posedge clk);
         waitCycles++;
      end
      if (expData.size() != 0)
      begin
         errors++;
         $display("Timed out waiting for %0d writebacks that never arrived",
                  expData.size());
      end
      repeat (6) @(posedge clk);    // Room for a late stray strobe
      checkValue("strobe count", strobeCount, expectedCount);

      $display("Checks done with %0d errors", errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end
endmodule

/* bench/trace.txt */
# instr(hex) gap(idle cycles before it) wb(1 if a writeback is expected)
# then expected reg, data and NZCV after it, all three in hex
E2801005 2 1 1 00000005 0
E2812003 0 1 2 00000008 0
E38030F0 0 1 3 000000F0 0
E0814002 0 1 4 0000000D 0
E2445001 0 1 5 0000000C 0
E203603C 1 1 6 00000030 0
E0437001 0 1 7 000000EB 0
E1818006 0 1 8 00000035 0
E0039007 2 1 9 000000E0 0
E080A201 0 1 A 00000050 0
E180B223 1 1 B 0000000F 0
E040C003 0 1 C FFFFFF10 0
E080D24C 0 1 D FFFFFFF1 0
E180E461 3 1 E 05000000 0
E180F063 0 1 F 000000F0 0
E1802F81 0 1 2 80000000 0
E0513001 2 1 3 00000000 6
02814001 0 1 4 00000006 6
12815001 0 0 0 00000000 0
E0126002 1 1 6 80000000 A
E0927002 0 1 7 00000000 7
E3918000 0 1 8 00000005 3
A2809007 0 0 0 00000000 0
B2809007 0 1 9 00000007 3
8280A009 1 1 A 00000009 3
0051B001 0 0 0 00000000 0
F280C001 0 0 0 00000000 0
E250C001 2 1 C FFFFFFFF 8
B28CD002 0 1 D 00000001 8
8280E001 0 0 0 00000000 0
E252E001 0 1 E 7FFFFFFF 3
108EF00E 0 1 F FFFFFFFE 3
E5912000 1 0 0 00000000 0
EA000004 0 0 0 00000000 0
E0213002 0 0 0 00000000 0
E3A01001 0 0 0 00000000 0
E2822000 0 1 2 80000000 3
E08F000D 0 1 0 FFFFFFFF 3

/* verilog.f */
src/armPkg.sv
src/instrDecoder.sv
src/operandStage.sv
src/shiftAlu.sv
src/executeUnit.sv
src/armCore.sv
bench/armCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the core and testbench with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module armCoreTb -f verilog.f -o armCoreSim \
   && ./obj_dir/armCoreSim > sim.log 2>&1 \
   || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result found in the log"; exit 1; }
echo "Simulation passed"
